//--- source/isa_pkg.sv
package isa_pkg;

    localparam int INSTR_WIDTH    = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // RV32I major opcodes, instr[6:0].
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // The only funct7 values an RV32I encoding may carry.
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

endpackage

//--- source/ctrl_pkg.sv
package ctrl_pkg;

    // Immediate format for the execute stage.
    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT, IMM_ZIMM
    } imm_type_e;

    // Order follows funct3 of OP and OP-IMM.
    typedef enum logic [2:0] {
        ALU_OP_ADD_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU,
        ALU_OP_XOR, ALU_OP_SRL_SRA, ALU_OP_OR, ALU_OP_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_SRC1_REG, ALU_SRC1_PC, ALU_SRC1_ZERO
    } alu_src1_e;

    typedef enum logic [1:0] {
        ALU_SRC2_REG, ALU_SRC2_IMM, ALU_SRC2_FOUR
    } alu_src2_e;

    // Order follows funct3[1:0] of loads and stores.
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE, MEM_WIDTH_HALF, MEM_WIDTH_WORD
    } mem_width_e;

    typedef enum logic [1:0] {
        BRANCH_OP_NEVER, BRANCH_OP_ZERO, BRANCH_OP_NON_ZERO, BRANCH_OP_ALWAYS
    } branch_op_e;

    typedef enum logic {
        BRANCH_PC_SRC_IMM, BRANCH_PC_SRC_REG
    } branch_pc_src_e;

    typedef enum logic [1:0] {
        CSR_WRITE_OP_RW, CSR_WRITE_OP_RS, CSR_WRITE_OP_RC
    } csr_write_op_e;

    typedef enum logic {
        CSR_SRC_REG, CSR_SRC_IMM
    } csr_src_e;

endpackage

//--- source/alu_decode.sv
module alu_decode import isa_pkg::*, ctrl_pkg::*; (
    input  logic [INSTR_WIDTH-1:0] instr,
    output logic                   hit,
    output logic                   rs1_read,
    output logic                   rs2_read,
    output imm_type_e              imm_type,
    output alu_op_e                alu_op,
    output logic                   alu_sub_sra,
    output alu_src1_e              alu_src1,
    output alu_src2_e              alu_src2,
    output logic                   rd_write
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       slt_type;
    logic       f7_alt;
    logic       f7_any;

    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign slt_type = funct3[2:1] == 2'b01;
    assign f7_alt   = funct7 == F7_ALT;
    assign f7_any   = (funct7 == F7_BASE) || f7_alt;

    always_comb begin
        hit         = 1'b0;
        rs1_read    = 1'b0;
        rs2_read    = 1'b0;
        imm_type    = IMM_I;
        alu_op      = ALU_OP_ADD_SUB;
        alu_sub_sra = 1'b0;
        alu_src1    = ALU_SRC1_REG;
        alu_src2    = ALU_SRC2_REG;
        rd_write    = 1'b0;
        case (opcode_e'(instr[6:0]))
            OPC_LUI, OPC_AUIPC: begin
                hit      = 1'b1;
                imm_type = IMM_U;
                alu_src1 = (instr[6:0] == OPC_LUI) ? ALU_SRC1_ZERO : ALU_SRC1_PC;
                alu_src2 = ALU_SRC2_IMM;
                rd_write = 1'b1;
            end
            OPC_OP_IMM: begin
                // Only the shifts carry a funct7 field.
                case (funct3)
                    3'd1:    hit = funct7 == F7_BASE;
                    3'd5:    hit = f7_any;
                    default: hit = 1'b1;
                endcase
                if (hit) begin
                    rs1_read    = 1'b1;
                    rd_write    = 1'b1;
                    imm_type    = (funct3[1:0] == 2'b01) ? IMM_SHAMT : IMM_I;
                    alu_op      = alu_op_e'(funct3);
                    alu_sub_sra = slt_type || (funct3 == 3'd5 && f7_alt);
                    alu_src2    = ALU_SRC2_IMM;
                end
            end
            OPC_OP: begin
                hit = (funct3 == 3'd0 || funct3 == 3'd5) ? f7_any : funct7 == F7_BASE;
                if (hit) begin
                    rs1_read    = 1'b1;
                    rs2_read    = 1'b1;
                    rd_write    = 1'b1;
                    alu_op      = alu_op_e'(funct3);
                    alu_sub_sra = slt_type || f7_alt;
                end
            end
            default: hit = 1'b0;
        endcase
    end

endmodule

//--- source/mem_decode.sv
module mem_decode import isa_pkg::*, ctrl_pkg::*; (
    input  logic [INSTR_WIDTH-1:0] instr,
    output logic                   hit,
    output logic                   rs1_read,
    output logic                   rs2_read,
    output imm_type_e              imm_type,
    output alu_op_e                alu_op,
    output logic                   alu_sub_sra,
    output alu_src1_e              alu_src1,
    output alu_src2_e              alu_src2,
    output logic                   rd_write,
    output logic                   mem_read,
    output logic                   mem_write,
    output mem_width_e             mem_width,
    output logic                   mem_zero_extend,
    output logic                   mem_fence
);

    logic [2:0] funct3;

    assign funct3 = instr[14:12];

    // Address is always rs1 plus immediate.
    assign alu_op      = ALU_OP_ADD_SUB;
    assign alu_sub_sra = 1'b0;
    assign alu_src1    = ALU_SRC1_REG;

    always_comb begin
        hit             = 1'b0;
        rs1_read        = 1'b0;
        rs2_read        = 1'b0;
        imm_type        = IMM_I;
        alu_src2        = ALU_SRC2_REG;
        rd_write        = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_width       = MEM_WIDTH_BYTE;
        mem_zero_extend = 1'b0;
        mem_fence       = 1'b0;
        case (opcode_e'(instr[6:0]))
            OPC_LOAD: begin
                // LB, LH, LW, LBU, LHU.
                hit = funct3[1:0] != 2'b11 && funct3 != 3'd6;
                if (hit) begin
                    rs1_read        = 1'b1;
                    rd_write        = 1'b1;
                    alu_src2        = ALU_SRC2_IMM;
                    mem_read        = 1'b1;
                    mem_width       = mem_width_e'(funct3[1:0]);
                    mem_zero_extend = funct3[2];
                end
            end
            OPC_STORE: begin
                hit = funct3[2] == 1'b0 && funct3[1:0] != 2'b11;
                if (hit) begin
                    rs1_read  = 1'b1;
                    rs2_read  = 1'b1;
                    imm_type  = IMM_S;
                    alu_src2  = ALU_SRC2_IMM;
                    mem_write = 1'b1;
                    mem_width = mem_width_e'(funct3[1:0]);
                end
            end
            OPC_MISC_MEM: begin
                // FENCE is a no-op here. FENCE.I flushes.
                hit       = funct3[2:1] == 2'b00;
                mem_fence = hit && funct3[0];
            end
            default: hit = 1'b0;
        endcase
    end

endmodule

//--- source/branch_decode.sv
module branch_decode import isa_pkg::*, ctrl_pkg::*; (
    input  logic [INSTR_WIDTH-1:0] instr,
    output logic                   hit,
    output logic                   rs1_read,
    output logic                   rs2_read,
    output imm_type_e              imm_type,
    output alu_op_e                alu_op,
    output logic                   alu_sub_sra,
    output alu_src1_e              alu_src1,
    output alu_src2_e              alu_src2,
    output logic                   rd_write,
    output branch_op_e             branch_op,
    output branch_pc_src_e         branch_pc_src
);

    logic [2:0] funct3;

    assign funct3 = instr[14:12];

    always_comb begin
        hit           = 1'b0;
        rs1_read      = 1'b0;
        rs2_read      = 1'b0;
        imm_type      = IMM_I;
        alu_op        = ALU_OP_ADD_SUB;
        alu_sub_sra   = 1'b0;
        alu_src1      = ALU_SRC1_REG;
        alu_src2      = ALU_SRC2_REG;
        rd_write      = 1'b0;
        branch_op     = BRANCH_OP_NEVER;
        branch_pc_src = BRANCH_PC_SRC_IMM;
        case (opcode_e'(instr[6:0]))
            OPC_JAL, OPC_JALR: begin
                hit = (instr[6:0] == OPC_JAL) || (funct3 == 3'd0);
                if (hit) begin
                    // Link value is pc + 4.
                    alu_src1  = ALU_SRC1_PC;
                    alu_src2  = ALU_SRC2_FOUR;
                    rd_write  = 1'b1;
                    branch_op = BRANCH_OP_ALWAYS;
                    if (instr[6:0] == OPC_JAL) begin
                        imm_type = IMM_J;
                    end else begin
                        rs1_read      = 1'b1;
                        branch_pc_src = BRANCH_PC_SRC_REG;
                    end
                end
            end
            OPC_BRANCH: begin
                hit = funct3[2:1] != 2'b01;
                if (hit) begin
                    rs1_read    = 1'b1;
                    rs2_read    = 1'b1;
                    imm_type    = IMM_B;
                    alu_sub_sra = 1'b1;
                    if (funct3[2]) begin
                        alu_op = funct3[1] ? ALU_OP_SLTU : ALU_OP_SLT;
                    end
                    // BEQ, BGE and BGEU take the branch on a zero result.
                    branch_op = (funct3[0] ^ funct3[2]) ? BRANCH_OP_NON_ZERO : BRANCH_OP_ZERO;
                end
            end
            default: hit = 1'b0;
        endcase
    end

endmodule

//--- source/csr_decode.sv
module csr_decode import isa_pkg::*, ctrl_pkg::*; #(
    parameter bit ENABLE_ZICSR = 1'b1
) (
    input  logic [INSTR_WIDTH-1:0] instr,
    output logic                   hit,
    output logic                   rs1_read,
    output imm_type_e              imm_type,
    output logic                   rd_write,
    output logic                   csr_read,
    output logic                   csr_write,
    output csr_write_op_e          csr_write_op,
    output csr_src_e               csr_src
);

    logic [2:0]                funct3;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic                      rw_form;

    assign funct3  = instr[14:12];
    assign rd      = instr[11:7];
    assign rs1     = instr[19:15];
    assign rw_form = funct3[1:0] == 2'b01;

    // funct3 0 and 4 are not CSR instructions.
    assign hit = ENABLE_ZICSR && instr[6:0] == OPC_SYSTEM && funct3[1:0] != 2'b00;

    always_comb begin
        rs1_read     = 1'b0;
        imm_type     = IMM_I;
        rd_write     = 1'b0;
        csr_read     = 1'b0;
        csr_write    = 1'b0;
        csr_write_op = CSR_WRITE_OP_RW;
        csr_src      = CSR_SRC_REG;
        if (hit) begin
            // The immediate forms put zimm in the rs1 field.
            rs1_read     = !funct3[2];
            imm_type     = funct3[2] ? IMM_ZIMM : IMM_I;
            csr_src      = funct3[2] ? CSR_SRC_IMM : CSR_SRC_REG;
            csr_write_op = csr_write_op_e'(funct3[1:0] - 2'd1);
            if (rw_form) begin
                // No CSR read side effects when rd is x0.
                csr_write = 1'b1;
                csr_read  = rd != '0;
                rd_write  = rd != '0;
            end else begin
                csr_read  = 1'b1;
                rd_write  = 1'b1;
                csr_write = rs1 != '0;
            end
        end
    end

endmodule

//--- source/decode_stage_reg.sv
module decode_stage_reg import ctrl_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_valid,
    input  logic           ad_hit, md_hit, bd_hit, cd_hit,
    input  logic           ad_rs1_read, md_rs1_read, bd_rs1_read, cd_rs1_read,
    input  logic           ad_rs2_read, md_rs2_read, bd_rs2_read,
    input  imm_type_e      ad_imm_type, md_imm_type, bd_imm_type, cd_imm_type,
    input  alu_op_e        ad_alu_op, md_alu_op, bd_alu_op,
    input  logic           ad_alu_sub_sra, md_alu_sub_sra, bd_alu_sub_sra,
    input  alu_src1_e      ad_alu_src1, md_alu_src1, bd_alu_src1,
    input  alu_src2_e      ad_alu_src2, md_alu_src2, bd_alu_src2,
    input  logic           ad_rd_write, md_rd_write, bd_rd_write, cd_rd_write,
    input  logic           md_mem_read, md_mem_write, md_mem_zero_extend, md_mem_fence,
    input  mem_width_e     md_mem_width,
    input  branch_op_e     bd_branch_op,
    input  branch_pc_src_e bd_branch_pc_src,
    input  logic           cd_csr_read, cd_csr_write,
    input  csr_write_op_e  cd_csr_write_op,
    input  csr_src_e       cd_csr_src,
    output logic           ctrl_valid,
    output logic           illegal,
    output logic           rs1_read,
    output logic           rs2_read,
    output imm_type_e      imm_type,
    output alu_op_e        alu_op,
    output logic           alu_sub_sra,
    output alu_src1_e      alu_src1,
    output alu_src2_e      alu_src2,
    output logic           mem_read,
    output logic           mem_write,
    output mem_width_e     mem_width,
    output logic           mem_zero_extend,
    output logic           mem_fence,
    output logic           csr_read,
    output logic           csr_write,
    output csr_write_op_e  csr_write_op,
    output csr_src_e       csr_src,
    output branch_op_e     branch_op,
    output branch_pc_src_e branch_pc_src,
    output logic           rd_write
);

    logic any_hit;
    logic load_en;

    // Opcodes are disjoint, so at most one class hits.
    assign any_hit = ad_hit | md_hit | bd_hit | cd_hit;
    assign load_en = instr_valid & any_hit;

    // ------------------------------------------------
    // Strobes and control state
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_valid <= 1'b0;
            illegal    <= 1'b0;
            rs1_read   <= 1'b0;
            rs2_read   <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            mem_fence  <= 1'b0;
            csr_read   <= 1'b0;
            csr_write  <= 1'b0;
            branch_op  <= BRANCH_OP_NEVER;
            rd_write   <= 1'b0;
        end else begin
            ctrl_valid <= load_en;
            illegal    <= instr_valid & ~any_hit;
            rs1_read   <= load_en & (ad_rs1_read | md_rs1_read | bd_rs1_read | cd_rs1_read);
            rs2_read   <= load_en & (ad_rs2_read | md_rs2_read | bd_rs2_read);
            mem_read   <= load_en & md_mem_read;
            mem_write  <= load_en & md_mem_write;
            mem_fence  <= load_en & md_mem_fence;
            csr_read   <= load_en & cd_csr_read;
            csr_write  <= load_en & cd_csr_write;
            branch_op  <= load_en ? bd_branch_op : BRANCH_OP_NEVER;
            rd_write   <= load_en & (ad_rd_write | md_rd_write | bd_rd_write | cd_rd_write);
        end
    end

    // ------------------------------------------------
    // Operand and format fields
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        imm_type        <= load_en ?
                           imm_type_e'(ad_imm_type | md_imm_type | bd_imm_type | cd_imm_type) :
                           IMM_I;
        alu_op          <= load_en ? alu_op_e'(ad_alu_op | md_alu_op | bd_alu_op) : ALU_OP_ADD_SUB;
        alu_sub_sra     <= load_en & (ad_alu_sub_sra | md_alu_sub_sra | bd_alu_sub_sra);
        alu_src1        <= load_en ? alu_src1_e'(ad_alu_src1 | md_alu_src1 | bd_alu_src1) :
                           ALU_SRC1_REG;
        alu_src2        <= load_en ? alu_src2_e'(ad_alu_src2 | md_alu_src2 | bd_alu_src2) :
                           ALU_SRC2_REG;
        mem_width       <= load_en ? md_mem_width : MEM_WIDTH_BYTE;
        mem_zero_extend <= load_en & md_mem_zero_extend;
        csr_write_op    <= load_en ? cd_csr_write_op : CSR_WRITE_OP_RW;
        csr_src         <= load_en ? cd_csr_src : CSR_SRC_REG;
        branch_pc_src   <= load_en ? bd_branch_pc_src : BRANCH_PC_SRC_IMM;
    end

endmodule

//--- source/control_unit.sv
module control_unit import isa_pkg::*, ctrl_pkg::*; #(
    parameter bit ENABLE_ZICSR = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INSTR_WIDTH-1:0] instr,
    input  logic                   instr_valid,
    output logic                   ctrl_valid,
    output logic                   illegal,
    output logic                   rs1_read,
    output logic                   rs2_read,
    output imm_type_e              imm_type,
    output alu_op_e                alu_op,
    output logic                   alu_sub_sra,
    output alu_src1_e              alu_src1,
    output alu_src2_e              alu_src2,
    output logic                   mem_read,
    output logic                   mem_write,
    output mem_width_e             mem_width,
    output logic                   mem_zero_extend,
    output logic                   mem_fence,
    output logic                   csr_read,
    output logic                   csr_write,
    output csr_write_op_e          csr_write_op,
    output csr_src_e               csr_src,
    output branch_op_e             branch_op,
    output branch_pc_src_e         branch_pc_src,
    output logic                   rd_write
);

    logic           ad_hit, md_hit, bd_hit, cd_hit;
    logic           ad_rs1_read, md_rs1_read, bd_rs1_read, cd_rs1_read;
    logic           ad_rs2_read, md_rs2_read, bd_rs2_read;
    imm_type_e      ad_imm_type, md_imm_type, bd_imm_type, cd_imm_type;
    alu_op_e        ad_alu_op, md_alu_op, bd_alu_op;
    logic           ad_alu_sub_sra, md_alu_sub_sra, bd_alu_sub_sra;
    alu_src1_e      ad_alu_src1, md_alu_src1, bd_alu_src1;
    alu_src2_e      ad_alu_src2, md_alu_src2, bd_alu_src2;
    logic           ad_rd_write, md_rd_write, bd_rd_write, cd_rd_write;
    logic           md_mem_read, md_mem_write, md_mem_zero_extend, md_mem_fence;
    mem_width_e     md_mem_width;
    branch_op_e     bd_branch_op;
    branch_pc_src_e bd_branch_pc_src;
    logic           cd_csr_read, cd_csr_write;
    csr_write_op_e  cd_csr_write_op;
    csr_src_e       cd_csr_src;

    // ------------------------------------------------
    // Class decoders
    // ------------------------------------------------
    alu_decode alu_decode_inst (
        .instr(instr), .hit(ad_hit), .rs1_read(ad_rs1_read), .rs2_read(ad_rs2_read),
        .imm_type(ad_imm_type), .alu_op(ad_alu_op), .alu_sub_sra(ad_alu_sub_sra),
        .alu_src1(ad_alu_src1), .alu_src2(ad_alu_src2), .rd_write(ad_rd_write)
    );

    mem_decode mem_decode_inst (
        .instr(instr), .hit(md_hit), .rs1_read(md_rs1_read), .rs2_read(md_rs2_read),
        .imm_type(md_imm_type), .alu_op(md_alu_op), .alu_sub_sra(md_alu_sub_sra),
        .alu_src1(md_alu_src1), .alu_src2(md_alu_src2), .rd_write(md_rd_write),
        .mem_read(md_mem_read), .mem_write(md_mem_write), .mem_width(md_mem_width),
        .mem_zero_extend(md_mem_zero_extend), .mem_fence(md_mem_fence)
    );

    branch_decode branch_decode_inst (
        .instr(instr), .hit(bd_hit), .rs1_read(bd_rs1_read), .rs2_read(bd_rs2_read),
        .imm_type(bd_imm_type), .alu_op(bd_alu_op), .alu_sub_sra(bd_alu_sub_sra),
        .alu_src1(bd_alu_src1), .alu_src2(bd_alu_src2), .rd_write(bd_rd_write),
        .branch_op(bd_branch_op), .branch_pc_src(bd_branch_pc_src)
    );

    csr_decode #(
        .ENABLE_ZICSR(ENABLE_ZICSR)
    ) csr_decode_inst (
        .instr(instr), .hit(cd_hit), .rs1_read(cd_rs1_read), .imm_type(cd_imm_type),
        .rd_write(cd_rd_write), .csr_read(cd_csr_read), .csr_write(cd_csr_write),
        .csr_write_op(cd_csr_write_op), .csr_src(cd_csr_src)
    );

    // ------------------------------------------------
    // Output register
    // ------------------------------------------------
    decode_stage_reg decode_stage_reg_inst (
        .clk(clk), .rst(rst), .instr_valid(instr_valid),
        .ad_hit(ad_hit), .md_hit(md_hit), .bd_hit(bd_hit), .cd_hit(cd_hit),
        .ad_rs1_read(ad_rs1_read), .md_rs1_read(md_rs1_read),
        .bd_rs1_read(bd_rs1_read), .cd_rs1_read(cd_rs1_read),
        .ad_rs2_read(ad_rs2_read), .md_rs2_read(md_rs2_read), .bd_rs2_read(bd_rs2_read),
        .ad_imm_type(ad_imm_type), .md_imm_type(md_imm_type),
        .bd_imm_type(bd_imm_type), .cd_imm_type(cd_imm_type),
        .ad_alu_op(ad_alu_op), .md_alu_op(md_alu_op), .bd_alu_op(bd_alu_op),
        .ad_alu_sub_sra(ad_alu_sub_sra), .md_alu_sub_sra(md_alu_sub_sra),
        .bd_alu_sub_sra(bd_alu_sub_sra),
        .ad_alu_src1(ad_alu_src1), .md_alu_src1(md_alu_src1), .bd_alu_src1(bd_alu_src1),
        .ad_alu_src2(ad_alu_src2), .md_alu_src2(md_alu_src2), .bd_alu_src2(bd_alu_src2),
        .ad_rd_write(ad_rd_write), .md_rd_write(md_rd_write),
        .bd_rd_write(bd_rd_write), .cd_rd_write(cd_rd_write),
        .md_mem_read(md_mem_read), .md_mem_write(md_mem_write),
        .md_mem_zero_extend(md_mem_zero_extend), .md_mem_fence(md_mem_fence),
        .md_mem_width(md_mem_width),
        .bd_branch_op(bd_branch_op), .bd_branch_pc_src(bd_branch_pc_src),
        .cd_csr_read(cd_csr_read), .cd_csr_write(cd_csr_write),
        .cd_csr_write_op(cd_csr_write_op), .cd_csr_src(cd_csr_src),
        .ctrl_valid(ctrl_valid), .illegal(illegal),
        .rs1_read(rs1_read), .rs2_read(rs2_read), .imm_type(imm_type),
        .alu_op(alu_op), .alu_sub_sra(alu_sub_sra),
        .alu_src1(alu_src1), .alu_src2(alu_src2),
        .mem_read(mem_read), .mem_write(mem_write), .mem_width(mem_width),
        .mem_zero_extend(mem_zero_extend), .mem_fence(mem_fence),
        .csr_read(csr_read), .csr_write(csr_write),
        .csr_write_op(csr_write_op), .csr_src(csr_src),
        .branch_op(branch_op), .branch_pc_src(branch_pc_src), .rd_write(rd_write)
    );

endmodule

//--- dv/control_unit_assertions.sv
module control_unit_assertions (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input logic ctrl_valid,
    input logic illegal,
    input logic mem_read,
    input logic mem_write
);

    // A load and a store never share one instruction.
    mem_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write both high");

    valid_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(ctrl_valid && illegal)
    ) else $error("ctrl_valid and illegal both high");

    // One cycle of latency.
    valid_follows_input: assert property (
        @(posedge clk) disable iff (rst) ctrl_valid |-> $past(instr_valid)
    ) else $error("ctrl_valid without instr_valid one cycle earlier");

endmodule

bind decode_stage_reg control_unit_assertions assertions_inst (
    .clk(clk), .rst(rst), .instr_valid(instr_valid), .ctrl_valid(ctrl_valid),
    .illegal(illegal), .mem_read(mem_read), .mem_write(mem_write)
);

//--- dv/control_unit_tb.sv
module control_unit_tb import isa_pkg::*, ctrl_pkg::*; ();

    localparam int NUM_FIELDS = 21;
    localparam int MAX_CYCLES = 2000;

    // JALR, so the strobes and branch_op would be set without reset.
    localparam logic [INSTR_WIDTH-1:0] RESET_INSTR = 32'h000100e7;

    logic                   clk;
    logic                   rst;
    logic [INSTR_WIDTH-1:0] instr;
    logic                   instr_valid;

    logic           ctrl_valid, illegal, rs1_read, rs2_read, alu_sub_sra;
    logic           mem_read, mem_write, mem_zero_extend, mem_fence;
    logic           csr_read, csr_write, rd_write;
    imm_type_e      imm_type;
    alu_op_e        alu_op;
    alu_src1_e      alu_src1;
    alu_src2_e      alu_src2;
    mem_width_e     mem_width;
    csr_write_op_e  csr_write_op;
    csr_src_e       csr_src;
    branch_op_e     branch_op;
    branch_pc_src_e branch_pc_src;

    logic [31:0] vec_instr[$];
    int          vec_exp[$];
    logic [31:0] rng;
    int          errors;
    int          tests;

    string field_names[NUM_FIELDS] = '{
        "ctrl_valid", "illegal", "rs1_read", "rs2_read", "imm_type", "alu_op",
        "alu_sub_sra", "alu_src1", "alu_src2", "mem_read", "mem_write", "mem_width",
        "mem_zero_extend", "mem_fence", "csr_read", "csr_write", "csr_write_op",
        "csr_src", "branch_op", "branch_pc_src", "rd_write"
    };

    control_unit #(
        .ENABLE_ZICSR(1'b1)
    ) control_unit_inst (
        .clk(clk), .rst(rst), .instr(instr), .instr_valid(instr_valid),
        .ctrl_valid(ctrl_valid), .illegal(illegal), .rs1_read(rs1_read),
        .rs2_read(rs2_read), .imm_type(imm_type), .alu_op(alu_op),
        .alu_sub_sra(alu_sub_sra), .alu_src1(alu_src1), .alu_src2(alu_src2),
        .mem_read(mem_read), .mem_write(mem_write), .mem_width(mem_width),
        .mem_zero_extend(mem_zero_extend), .mem_fence(mem_fence),
        .csr_read(csr_read), .csr_write(csr_write), .csr_write_op(csr_write_op),
        .csr_src(csr_src), .branch_op(branch_op), .branch_pc_src(branch_pc_src),
        .rd_write(rd_write)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog for the whole run.
    initial begin
        for (int cycle = 0; cycle < MAX_CYCLES; cycle++) begin
            @(posedge clk);
        end
        $display("Simulation did not finish within %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic check_field(input string name, input int expected, input int actual,
                               inout int fails);
        assert (expected == actual) else begin
            $display("ERR t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
            fails++;
        end
    endtask

    function automatic int sample_field(input int idx);
        int values[NUM_FIELDS];
        values = '{
            int'(ctrl_valid), int'(illegal), int'(rs1_read), int'(rs2_read),
            int'(imm_type), int'(alu_op), int'(alu_sub_sra), int'(alu_src1),
            int'(alu_src2), int'(mem_read), int'(mem_write), int'(mem_width),
            int'(mem_zero_extend), int'(mem_fence), int'(csr_read), int'(csr_write),
            int'(csr_write_op), int'(csr_src), int'(branch_op), int'(branch_pc_src),
            int'(rd_write)
        };
        return values[idx];
    endfunction

    // All strobes low, branch_op NEVER.
    task automatic check_quiet(input string label);
        int fails;
        fails = 0;
        foreach (field_names[k]) begin
            if (k < 4 || (k >= 9 && k <= 10) || k == 13 || k == 14 || k == 15
                    || k == 18 || k == 20) begin
                check_field(field_names[k], 0, sample_field(k), fails);
            end
        end
        tests++;
        $display("test %0d %s: %s", tests, label, fails == 0 ? "ok" : "FAILED");
    endtask

    task automatic run_vector(input int idx, input int gap);
        int fails;
        fails = 0;
        instr       = vec_instr[idx];
        instr_valid = 1'b1;
        next_edge();
        for (int k = 0; k < NUM_FIELDS; k++) begin
            check_field(field_names[k], vec_exp[idx*NUM_FIELDS+k], sample_field(k), fails);
        end
        tests++;
        $display("test %0d vector %0d instr %08h gap %0d: %s", tests, idx, vec_instr[idx],
                 gap, fails == 0 ? "ok" : "FAILED");
        instr_valid = 1'b0;
        for (int g = 0; g < gap; g++) begin
            instr = rng;
            next_edge();
            check_quiet("idle cycle");
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          count;
        string       line;
        logic [31:0] word;
        int          e[NUM_FIELDS];
        fd = $fopen("dv/decode_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/decode_input.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    count = $sscanf(line,
                        "%h %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        word, e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7], e[8], e[9],
                        e[10], e[11], e[12], e[13], e[14], e[15], e[16], e[17], e[18],
                        e[19], e[20]);
                    if (count != NUM_FIELDS + 1) begin
                        $display("Malformed line in stimulus file: %s", line);
                        errors++;
                    end else begin
                        vec_instr.push_back(word);
                        foreach (e[k]) vec_exp.push_back(e[k]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int gap;
        rst         = 1'b1;
        instr       = RESET_INSTR;
        instr_valid = 1'b1;
        errors      = 0;
        tests       = 0;
        rng         = 32'hde51b771;
        load_vectors();

        // --------------------------------------------------
        // Reset
        // --------------------------------------------------
        next_edge();
        next_edge();
        check_quiet("during reset");
        next_edge();
        next_edge();
        rst         = 1'b0;
        instr_valid = 1'b0;
        next_edge();
        check_quiet("first cycle after reset");

        // Random idle gaps between vectors.
        for (int i = 0; i < vec_instr.size(); i++) begin
            rng = xorshift32(rng);
            gap = int'(rng % 32'd3);
            run_vector(i, gap);
        end

        // --------------------------------------------------
        // Back-to-back streaming
        // --------------------------------------------------
        for (int i = 0; i < vec_instr.size(); i++) begin
            run_vector(i, 0);
        end
        next_edge();
        check_quiet("drain");

        $display("%0d tests, %0d vectors, %0d errors", tests, vec_instr.size(), errors);
        if (errors == 0 && vec_instr.size() > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- dv/decode_input.txt
# instr(hex) ctrl_valid illegal rs1_read rs2_read imm_type alu_op alu_sub_sra alu_src1 alu_src2
# mem_read mem_write mem_width mem_zero_extend mem_fence csr_read csr_write csr_write_op csr_src branch_op branch_pc_src rd_write
123450B7 1 0 0 0 3 0 0 2 1 0 0 0 0 0 0 0 0 0 0 0 1
12345097 1 0 0 0 3 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 1
00510093 1 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1
FFF12093 1 0 1 0 0 2 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1
FFF13093 1 0 1 0 0 3 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1
00311093 1 0 1 0 5 1 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1
00315093 1 0 1 0 5 5 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1
40315093 1 0 1 0 5 5 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1
003100B3 1 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
403100B3 1 0 1 1 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1
403150B3 1 0 1 1 0 5 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1
003120B3 1 0 1 1 0 2 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1
00410083 1 0 1 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0 1
00411083 1 0 1 0 0 0 0 0 1 1 0 1 0 0 0 0 0 0 0 0 1
00412083 1 0 1 0 0 0 0 0 1 1 0 2 0 0 0 0 0 0 0 0 1
00414083 1 0 1 0 0 0 0 0 1 1 0 0 1 0 0 0 0 0 0 0 1
00415083 1 0 1 0 0 0 0 0 1 1 0 1 1 0 0 0 0 0 0 0 1
00310223 1 0 1 1 1 0 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0
00311223 1 0 1 1 1 0 0 0 1 0 1 1 0 0 0 0 0 0 0 0 0
00312223 1 0 1 1 1 0 0 0 1 0 1 2 0 0 0 0 0 0 0 0 0
0FF0000F 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0000100F 1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0
008000EF 1 0 0 0 4 0 0 1 2 0 0 0 0 0 0 0 0 0 3 0 1
000100E7 1 0 1 0 0 0 0 1 2 0 0 0 0 0 0 0 0 0 3 1 1
00310463 1 0 1 1 2 0 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0
00311463 1 0 1 1 2 0 1 0 0 0 0 0 0 0 0 0 0 0 2 0 0
00314463 1 0 1 1 2 2 1 0 0 0 0 0 0 0 0 0 0 0 2 0 0
00315463 1 0 1 1 2 2 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0
00316463 1 0 1 1 2 3 1 0 0 0 0 0 0 0 0 0 0 0 2 0 0
00317463 1 0 1 1 2 3 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0
300110F3 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 1
30011073 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0
300120F3 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 0 0 1
300020F3 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 0 0 1
300130F3 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 1 2 0 0 0 1
3002D0F3 1 0 0 0 6 0 0 0 0 0 0 0 0 0 1 1 0 1 0 0 1
300060F3 1 0 0 0 6 0 0 0 0 0 0 0 0 0 1 0 1 1 0 0 1
3002F0F3 1 0 0 0 6 0 0 0 0 0 0 0 0 0 1 1 2 1 0 0 1
00000073 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
00312463 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
023100B3 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
FFFFFFFF 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

//--- project.f
source/isa_pkg.sv
source/ctrl_pkg.sv
source/alu_decode.sv
source/mem_decode.sv
source/branch_decode.sv
source/csr_decode.sv
source/decode_stage_reg.sv
source/control_unit.sv
dv/control_unit_assertions.sv
dv/control_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module control_unit_tb -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$output"; then
    exit 0
fi
exit 1
